/* Bender.yml */
package:
  name: spiMemory

sources:
  - verilog/spiMemoryPkg.sv
  - verilog/inputConditioner.sv
  - verilog/shiftRegister.sv
  - verilog/spiControl.sv
  - verilog/dataMemory.sv
  - verilog/spiMemory.sv
  - target: test
    files:
      - bench/spiMemoryBench.sv

/* bench/spiMemoryBench.sv */
`timescale 1ns/100ps

module spiMemoryBench;

  localparam int waitTime    = 3;
  localparam int halfPeriod  = 16;  // clk cycles per sclk half
  localparam int glitchLead  = 5;   // low-half cycles before the glitch
  localparam int glitchWidth = 2;   // shorter than waitTime + 1
  localparam int txCount     = 49;  // transactions in the whole run
  localparam int cycleLimit  = txCount * 17 * 32 * 3 / 2;

  // bus phases as the bench sees them
  localparam int idlePhase   = 0;
  localparam int headerPhase = 1;  // address and r/w bits
  localparam int turnPhase   = 2;  // high half of a read's r/w bit where enable may rise
  localparam int readPhase   = 3;
  localparam int writePhase  = 4;
  localparam int tailPhase   = 5;  // after the last read fall while enable may still be high

  logic clk;
  logic reset;
  logic sclkPin;
  logic csPin;
  logic mosiPin;
  logic misoPin;
  logic misoEnable;

  logic [15:0] lfsr;          // random source
  logic [7:0]  refMem [128];  // expected memory contents
  int          busPhase;
  int          testErrors;
  int          passCount;
  int          failCount;
  int          enableHighCount;  // negedges with enable high in a read
  bit          enableReported;
  int          cycleCount;
  string       testName;

  spiMemory #(.waitTime(waitTime)) i_spiMemory (
    .clk        (clk),
    .reset      (reset),
    .sclkPin    (sclkPin),
    .csPin      (csPin),
    .mosiPin    (mosiPin),
    .misoPin    (misoPin),
    .misoEnable (misoEnable)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  // taps 16 14 13 11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic takeRandom(input int count, output logic [7:0] value);
    value = '0;
    for (int b = 0; b < count; b++) begin
      value = {value[6:0], lfsr[15]};  // one step per bit
      lfsr  = lfsrNext(lfsr);
    end
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
    #1;  // drive just after the edge
  endtask

  task automatic startTest(input string name);
    testName       = name;
    testErrors     = 0;
    enableReported = 0;
  endtask

  task automatic endTest();
    if (testErrors == 0) begin
      $display("PASS %s", testName);
      passCount++;
    end else begin
      $display("FAIL %s with %0d errors", testName, testErrors);
      failCount++;
    end
  endtask

  task automatic checkByte(input logic [7:0] expected, input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s expected 0x%02h actual 0x%02h", testName, expected, actual);
      testErrors++;
    end
  endtask

  task automatic reportEnable(input string what);
    testErrors++;
    if (!enableReported) $display("%s: %s", testName, what);  // first one per test
    enableReported = 1;
  endtask

  // mode 0 master msb first with an optional short sclk pulse in one bit's low half
  task automatic spiTransfer(input logic readOp, input logic [6:0] addr,
                             input logic [7:0] writeByte, input int dataBits,
                             input int glitchAt, output logic [7:0] readByte);
    logic [15:0] frame;
    frame    = {addr, readOp, readOp ? 8'h00 : writeByte};
    readByte = '0;
    csPin    = 1'b0;
    busPhase = headerPhase;
    waitCycles(halfPeriod);
    for (int i = 0; i < 8 + dataBits; i++) begin
      mosiPin = frame[15-i];  // change in the low half
      if (i == glitchAt) begin
        waitCycles(glitchLead);
        sclkPin = 1'b1;
        waitCycles(glitchWidth);
        sclkPin = 1'b0;
        waitCycles(halfPeriod - glitchLead - glitchWidth);
      end else begin
        waitCycles(halfPeriod);
      end
      if (readOp && i >= 8) readByte = {readByte[6:0], misoPin};  // just before the rise
      sclkPin = 1'b1;
      if (readOp && i == 7) busPhase = turnPhase;
      waitCycles(halfPeriod);
      sclkPin = 1'b0;
      if (i == 7) busPhase = readOp ? readPhase : writePhase;
    end
    if (readOp) busPhase = tailPhase;
    waitCycles(halfPeriod);
    csPin    = 1'b1;
    busPhase = idlePhase;
    waitCycles(halfPeriod);  // cs high gap before the next frame
  endtask

  task automatic writeWord(input logic [6:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    spiTransfer(1'b0, addr, data, 8, -1, unused);
    refMem[addr] = data;  // only completed writes count
  endtask

  task automatic readWord(input logic [6:0] addr, input int glitchAt, output logic [7:0] data);
    spiTransfer(1'b1, addr, 8'h00, 8, glitchAt, data);
  endtask

  // enable rules checked between edges where everything is settled
  always @(negedge clk) begin
    if (!reset) begin
      if (csPin || busPhase == headerPhase || busPhase == writePhase) begin
        assert (!misoEnable) else reportEnable("misoEnable was high outside a read");
      end
      if (busPhase == readPhase) begin
        assert (misoEnable) else reportEnable("misoEnable was low during read data");
        if (misoEnable) enableHighCount++;
      end
    end
  end

  // run limit
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout after %0d cycles, the run did not finish", cycleCount);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [7:0] addrValue;
    logic [7:0] dataValue;
    logic [7:0] readValue;
    reset     = 1'b1;
    sclkPin   = 1'b0;  // mode 0 idles low
    csPin     = 1'b1;
    mosiPin   = 1'b0;
    lfsr      = 16'd63;
    busPhase  = idlePhase;
    passCount = 0;
    failCount = 0;
    enableHighCount = 0;
    for (int a = 0; a < 128; a++) refMem[a] = 8'h00;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    startTest("resetState");
    waitCycles(halfPeriod);
    checkByte(8'h00, {6'b0, misoEnable, misoPin});  // enable and miso both low
    endTest();

    startTest("writeThenRead");
    takeRandom(7, addrValue);
    takeRandom(8, dataValue);
    writeWord(addrValue[6:0], dataValue);
    readWord(addrValue[6:0], -1, readValue);
    checkByte(dataValue, readValue);
    endTest();

    startTest("randomTraffic");
    repeat (20) begin
      takeRandom(7, addrValue);
      takeRandom(8, dataValue);
      writeWord(addrValue[6:0], dataValue);
    end
    repeat (20) begin
      takeRandom(7, addrValue);
      readWord(addrValue[6:0], -1, readValue);
      checkByte(refMem[addrValue[6:0]], readValue);  // zero if never written
    end
    endTest();

    startTest("enableTiming");
    takeRandom(7, addrValue);
    writeWord(addrValue[6:0], 8'hA5);
    enableHighCount = 0;
    readWord(addrValue[6:0], -1, readValue);
    checkByte(8'hA5, readValue);
    assert (enableHighCount > 0) else begin
      $display("%s: misoEnable never went high during the read", testName);
      testErrors++;
    end
    endTest();

    startTest("abortedWrite");
    takeRandom(7, addrValue);
    takeRandom(8, dataValue);
    writeWord(addrValue[6:0], dataValue);
    spiTransfer(1'b0, addrValue[6:0], ~dataValue, 4, -1, readValue);  // cs up after 4 bits
    readWord(addrValue[6:0], -1, readValue);
    checkByte(dataValue, readValue);
    endTest();

    startTest("sclkGlitch");
    takeRandom(7, addrValue);
    takeRandom(8, dataValue);
    writeWord(addrValue[6:0], dataValue);
    readWord(addrValue[6:0], 3, readValue);  // short pulse inside address bit 3
    checkByte(dataValue, readValue);
    endTest();

    $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* spiMemory.f */
verilog/spiMemoryPkg.sv
verilog/inputConditioner.sv
verilog/shiftRegister.sv
verilog/spiControl.sv
verilog/dataMemory.sv
verilog/spiMemory.sv
bench/spiMemoryBench.sv

/* verilog/dataMemory.sv */
`timescale 1ns/100ps

module dataMemory (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              addrLoad,   // capture addressIn
  input  logic [spiMemoryPkg::addrBits-1:0] addressIn,
  input  logic                              memWrite,   // write writeData at stored address
  input  logic [spiMemoryPkg::wordBits-1:0] writeData,
  output logic [spiMemoryPkg::wordBits-1:0] readData   // word at stored address
);

  logic [spiMemoryPkg::addrBits-1:0] address;  // held for the whole transaction
  logic [spiMemoryPkg::wordBits-1:0] memory [spiMemoryPkg::memWords];

  always_ff @(posedge clk) begin
    if (reset) begin
      address <= '0;
    end else if (addrLoad) begin
      address <= addressIn;
    end
  end

  // storage, zeroed at reset so unwritten words read back as 0
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < spiMemoryPkg::memWords; i++) begin
        memory[i] <= '0;
      end
    end else if (memWrite) begin
      memory[address] <= writeData;
    end
  end

  // async read, valid the cycle after addrLoad
  assign readData = memory[address];

endmodule

/* verilog/inputConditioner.sv */
`timescale 1ns/100ps

module inputConditioner #(
  parameter int   waitTime   = 3,    // stable cycles required before adopting a change
  parameter logic resetLevel = 1'b0  // conditioned value after reset
) (
  input  logic clk,
  input  logic reset,
  input  logic noisy,         // raw asynchronous pin
  output logic conditioned,   // filtered level
  output logic positiveEdge,  // one cycle pulse on conditioned rising
  output logic negativeEdge   // one cycle pulse on conditioned falling
);

  localparam int cntBits = $clog2(waitTime + 1);
  localparam logic [cntBits-1:0] cntLimit = cntBits'(waitTime);

  logic                syncFirst;   // metastability catcher
  logic                syncSecond;  // safe to use from here on
  logic [cntBits-1:0]  stableCount;  // cycles that syncSecond has disagreed

  always_ff @(posedge clk) begin
    if (reset) begin
      syncFirst    <= resetLevel;
      syncSecond   <= resetLevel;
      conditioned  <= resetLevel;
      stableCount  <= '0;
      positiveEdge <= 1'b0;
      negativeEdge <= 1'b0;
    end else begin
      syncFirst    <= noisy;
      syncSecond   <= syncFirst;
      positiveEdge <= 1'b0;  // pulses default low
      negativeEdge <= 1'b0;
      if (syncSecond == conditioned) begin
        stableCount <= '0;  // glitch over or no change, start again
      end else if (stableCount == cntLimit) begin
        // held long enough, take it
        conditioned  <= syncSecond;
        stableCount  <= '0;
        positiveEdge <= syncSecond;
        negativeEdge <= ~syncSecond;
      end else begin
        stableCount <= stableCount + 1'b1;
      end
    end
  end

endmodule

/* verilog/shiftRegister.sv */
`timescale 1ns/100ps

module shiftRegister (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              sampleStrobe,  // sclk rising, take serialIn
  input  logic                              shiftStrobe,   // sclk falling, update serialOut
  input  logic                              serialIn,
  input  logic                              parallelLoad,  // load parallelIn, wins over sample
  input  logic [spiMemoryPkg::wordBits-1:0] parallelIn,
  output logic [spiMemoryPkg::wordBits-1:0] parallelOut,
  output logic                              serialOut
);

  localparam int topBit = spiMemoryPkg::wordBits - 1;

  logic [spiMemoryPkg::wordBits-1:0] buffer;  // the shift chain itself

  assign parallelOut = buffer;

  // shift chain, msb first, new bits enter at bit 0
  always_ff @(posedge clk) begin
    if (reset) begin
      buffer <= '0;
    end else if (parallelLoad) begin
      buffer <= parallelIn;
    end else if (sampleStrobe) begin
      buffer <= {buffer[topBit-1:0], serialIn};  // left shift moves next bit to the top
    end
  end

  // miso output stage
  // first read bit shows up straight from the load, the rest on falling edges
  always_ff @(posedge clk) begin
    if (reset) begin
      serialOut <= 1'b0;
    end else if (parallelLoad) begin
      serialOut <= parallelIn[topBit];  // bit 7 ready before the next falling edge
    end else if (shiftStrobe) begin
      serialOut <= buffer[topBit];
    end
  end

endmodule

/* verilog/spiControl.sv */
`timescale 1ns/100ps

module spiControl (
  input  logic clk,
  input  logic reset,
  input  logic chipSelectN,   // conditioned cs level that is high between transactions
  input  logic sampleStrobe,  // sclk rising
  input  logic shiftStrobe,   // sclk falling
  input  logic readWriteBit,  // shift register bit 0
  output logic addrLoad,      // capture address into memory
  output logic parallelLoad,  // load read word into shift register
  output logic memWrite,      // write shift register contents into memory
  output logic misoEnable     // slave owns the miso line
);

  localparam int countBits = $clog2(spiMemoryPkg::wordBits + 2);

  // counter end values for each phase
  localparam logic [countBits-1:0] lastAddr  = countBits'(spiMemoryPkg::addrBits - 1);
  localparam logic [countBits-1:0] lastData  = countBits'(spiMemoryPkg::wordBits - 1);
  localparam logic [countBits-1:0] lastShift = countBits'(spiMemoryPkg::wordBits);

  spiMemoryPkg::ctrlState state;
  logic [countBits-1:0]   bitCount;  // strobes seen in the current phase

  logic readSelected;  // r/w bit decoded as read in the loadRead cycle

  assign readSelected = (state == spiMemoryPkg::loadRead) && readWriteBit;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= spiMemoryPkg::idle;
      bitCount <= '0;
      addrLoad <= 1'b0;
    end else if (chipSelectN) begin
      // cs high aborts whatever is going on
      state    <= spiMemoryPkg::idle;
      bitCount <= '0;
      addrLoad <= 1'b0;
    end else begin
      addrLoad <= 1'b0;  // single cycle pulse
      case (state)
        spiMemoryPkg::idle: begin
          state    <= spiMemoryPkg::getAddress;  // cs is low here
          bitCount <= '0;
        end
        spiMemoryPkg::getAddress: begin
          if (sampleStrobe) begin
            if (bitCount == lastAddr) begin
              state    <= spiMemoryPkg::getReadWrite;
              bitCount <= '0;
              addrLoad <= 1'b1;  // address bits are in place next cycle
            end else begin
              bitCount <= bitCount + 1'b1;
            end
          end
        end
        spiMemoryPkg::getReadWrite: begin
          if (sampleStrobe) state <= spiMemoryPkg::loadRead;  // bit lands in bit 0 now
        end
        spiMemoryPkg::loadRead: begin
          // decide on the settled r/w bit
          state <= readWriteBit ? spiMemoryPkg::sendData : spiMemoryPkg::getData;
        end
        spiMemoryPkg::sendData: begin
          // first falling edge closes the r/w bit, then one per data bit
          if (shiftStrobe) begin
            if (bitCount == lastShift) begin
              state    <= spiMemoryPkg::idle;
              bitCount <= '0;
            end else begin
              bitCount <= bitCount + 1'b1;
            end
          end
        end
        spiMemoryPkg::getData: begin
          if (sampleStrobe) begin
            if (bitCount == lastData) begin
              state    <= spiMemoryPkg::commitWrite;  // full byte is in
              bitCount <= '0;
            end else begin
              bitCount <= bitCount + 1'b1;
            end
          end
        end
        spiMemoryPkg::commitWrite: begin
          state <= spiMemoryPkg::idle;
        end
        default: begin
          state    <= spiMemoryPkg::idle;
          bitCount <= '0;
        end
      endcase
    end
  end

  // decoded controls
  assign parallelLoad = readSelected;  // same cycle as the decision
  assign memWrite     = ~chipSelectN && (state == spiMemoryPkg::commitWrite);  // no write on abort
  assign misoEnable   = ~chipSelectN &&
                        (readSelected || (state == spiMemoryPkg::sendData));  // drops with cs

endmodule

/* verilog/spiMemory.sv */
`timescale 1ns/100ps

module spiMemory #(
  parameter int waitTime = 3  // conditioner filter length in clk cycles
) (
  input  logic clk,
  input  logic reset,
  input  logic sclkPin,     // spi clock from master, async
  input  logic csPin,       // chip select, active low, async
  input  logic mosiPin,     // master data in, async
  output logic misoPin,     // slave data out
  output logic misoEnable   // pad enable for misoPin
);

  logic sampleStrobe;  // sclk rise
  logic shiftStrobe;   // sclk fall
  logic chipSelectN;
  logic mosiBit;

  logic addrLoad;
  logic parallelLoad;
  logic memWrite;

  logic [spiMemoryPkg::wordBits-1:0] shiftData;  // shift register contents
  logic [spiMemoryPkg::wordBits-1:0] readData;   // addressed memory word

  // pin conditioning
  inputConditioner #(.waitTime(waitTime), .resetLevel(1'b0)) i_sclkConditioner (
    .clk          (clk),
    .reset        (reset),
    .noisy        (sclkPin),
    .conditioned  (),
    .positiveEdge (sampleStrobe),
    .negativeEdge (shiftStrobe)
  );

  inputConditioner #(.waitTime(waitTime), .resetLevel(1'b1)) i_csConditioner (
    .clk          (clk),
    .reset        (reset),
    .noisy        (csPin),
    .conditioned  (chipSelectN),  // idles high, no transaction
    .positiveEdge (),
    .negativeEdge ()
  );

  inputConditioner #(.waitTime(waitTime), .resetLevel(1'b0)) i_mosiConditioner (
    .clk          (clk),
    .reset        (reset),
    .noisy        (mosiPin),
    .conditioned  (mosiBit),
    .positiveEdge (),
    .negativeEdge ()
  );

  shiftRegister i_shiftRegister (
    .clk          (clk),
    .reset        (reset),
    .sampleStrobe (sampleStrobe),
    .shiftStrobe  (shiftStrobe),
    .serialIn     (mosiBit),
    .parallelLoad (parallelLoad),
    .parallelIn   (readData),
    .parallelOut  (shiftData),
    .serialOut    (misoPin)
  );

  spiControl i_spiControl (
    .clk          (clk),
    .reset        (reset),
    .chipSelectN  (chipSelectN),
    .sampleStrobe (sampleStrobe),
    .shiftStrobe  (shiftStrobe),
    .readWriteBit (shiftData[0]),  // last bit shifted in
    .addrLoad     (addrLoad),
    .parallelLoad (parallelLoad),
    .memWrite     (memWrite),
    .misoEnable   (misoEnable)
  );

  dataMemory i_dataMemory (
    .clk       (clk),
    .reset     (reset),
    .addrLoad  (addrLoad),
    .addressIn (shiftData[spiMemoryPkg::addrBits-1:0]),  // seven address bits at the bottom
    .memWrite  (memWrite),
    .writeData (shiftData),
    .readData  (readData)
  );

endmodule

/* verilog/spiMemoryPkg.sv */
package spiMemoryPkg;

  // transaction geometry
  localparam int addrBits = 7;  // address bits per transaction
  localparam int wordBits = 8;  // memory word and shift register width
  localparam int memWords = 2 ** addrBits;  // one word per address

  // controller sequencing
  typedef enum logic [2:0] {
    idle,          // waiting for chip select
    getAddress,    // shifting in address bits
    getReadWrite,  // waiting on the read/write bit
    loadRead,      // r/w bit now sits in shift register bit 0
    sendData,      // driving read data out on miso
    getData,       // shifting in write data
    commitWrite    // one cycle write into the memory
  } ctrlState;

endpackage
